/* files.f */
verilog/lsu_pkg.sv
verilog/mem_decoder.sv
verilog/mem_unit.sv
verilog/dcache_model.sv
verilog/load_align.sv
verilog/lsu_top.sv
dv/tb_clk_gen.sv
dv/tb_lsu_top.sv

/* dv/tb_lsu_top.sv */
// Load/store unit testbench
// Random loads and stores checked against a byte-wide memory model
`timescale 1ns/1ps

module tb_lsu_top;

    localparam int N_INSTR        = 400;
    localparam int TIMEOUT_CYCLES = N_INSTR * 20;

    logic            clk, rstn;
    logic            valid, kill;
    logic [31:0]     instr_w;
    lsu_pkg::bus64_t rs1_data, rs2_data;
    logic            lock, ready, xcpt;
    lsu_pkg::reg_t   rd_out;
    lsu_pkg::bus64_t data_out;

    logic [7:0]      ref_mem [int];   // Byte model, index is address mod 2 KiB
    int              acc_cnt;         // Requests accepted by the cache
    int              n_instr, cycle_cnt;
    int              err_data, err_xcpt, err_proto;

    // Seen during the current instruction
    int              ready_cnt, xcpt_cnt;
    int              since_issue;     // Cycles since the issue cycle
    int              ready_lat, xcpt_lat;
    logic            lock_seen;
    lsu_pkg::bus64_t got_data;
    lsu_pkg::reg_t   got_rd;

    tb_clk_gen u_clk (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    lsu_top DUT (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .valid_i    (valid),
        .kill_i     (kill),
        .instr_i    (instr_w),
        .data_rs1_i (rs1_data),
        .data_rs2_i (rs2_data),
        .lock_o     (lock),
        .ready_o    (ready),
        .rd_o       (rd_out),
        .data_o     (data_out),
        .xcpt_o     (xcpt)
    );

    // --------------------------------------------------
    // Monitor, samples mid-cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rstn) begin
            if (ready) begin
                ready_cnt++;
                ready_lat = since_issue;
                got_data  = data_out;
                got_rd    = rd_out;
            end
            if (xcpt) begin
                xcpt_cnt++;
                xcpt_lat = since_issue;
            end
            if (lock) lock_seen = 1'b1;
            since_issue++;
        end
    end

    // --------------------------------------------------
    // Model helpers
    // --------------------------------------------------
    function automatic logic [31:0] encode_load(logic [2:0] f3, lsu_pkg::reg_t dst,
                                                logic [11:0] imm);
        return {imm, 5'($urandom), f3, dst, lsu_pkg::OPC_LOAD};
    endfunction

    function automatic logic [31:0] encode_store(logic [2:0] f3, logic [11:0] imm);
        return {imm[11:5], 5'($urandom), 5'($urandom), f3, imm[4:0], lsu_pkg::OPC_STORE};
    endfunction

    // Next accept is the nacked one when seven came before it in the group of eight
    function automatic logic note_accept();
        logic nack;
        nack = (acc_cnt % 8 == 7);
        acc_cnt++;
        return nack;
    endfunction

    function automatic lsu_pkg::bus64_t load_value(lsu_pkg::addr_t a, logic [2:0] f3);
        int              n;
        lsu_pkg::bus64_t v;
        n = 1 << f3[1:0];
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[int'(a[10:0]) + i];
        end
        if (!f3[2] && n < 8 && v[8*n-1]) begin
            v = v | ({64{1'b1}} << (8 * n));   // Signed load, fill upper bytes
        end
        return v;
    endfunction

    task automatic check_load(input lsu_pkg::bus64_t exp_data, input lsu_pkg::bus64_t act_data,
                              input lsu_pkg::reg_t exp_rd, input lsu_pkg::reg_t act_rd);
        if (act_data !== exp_data) begin
            err_data++;
            $display("** Error: data_o expected %h got %h", exp_data, act_data);
        end
        if (act_rd !== exp_rd) begin
            err_data++;
            $display("** Error: rd_o expected %h got %h", exp_rd, act_rd);
        end
    endtask

    task automatic check_xcpt(input logic exp_x, input logic act_x);
        if (act_x !== exp_x) begin
            err_xcpt++;
            $display("** Error: xcpt_o expected %h got %h", exp_x, act_x);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    // kill_at: -1 none, 0 issue cycle, 1 cycle after
    task automatic run_instr(input logic [31:0] iw, input lsu_pkg::bus64_t a_rs1,
                             input lsu_pkg::bus64_t a_rs2, input int kill_at);
        @(posedge clk);
        #1;
        ready_cnt   = 0;
        xcpt_cnt    = 0;
        since_issue = 0;
        lock_seen   = 1'b0;
        valid       = 1'b1;
        instr_w     = iw;
        rs1_data    = a_rs1;
        rs2_data    = a_rs2;
        kill        = (kill_at == 0);
        @(posedge clk);
        #1;
        valid = 1'b0;
        kill  = (kill_at == 1);
        @(negedge clk);
        while (lock) @(negedge clk);   // Access ends when lock drops
        @(posedge clk);
        #1;
        kill = 1'b0;                   // One idle cycle between accesses
        n_instr++;
    endtask

    task automatic do_access(input logic is_st, input logic [2:0] f3,
                             input lsu_pkg::addr_t a, input int kill_at);
        logic [11:0]     imm;
        lsu_pkg::bus64_t a_rs1, a_rs2, exp_data;
        lsu_pkg::reg_t   dst;
        logic [31:0]     iw;
        int              n;
        int              exp_lat;
        logic            mis, io, exp_x, exp_ready;
        logic            nacked;
        imm   = 12'($urandom);
        dst   = 5'($urandom);
        a_rs2 = {$urandom, $urandom};
        a_rs1 = {24'd0, a} - {{52{imm[11]}}, imm};   // rs1 + imm lands on a
        iw    = is_st ? encode_store(f3, imm) : encode_load(f3, dst, imm);
        n     = 1 << f3[1:0];
        mis   = (a[2:0] & 3'(n - 1)) != 3'd0;
        io    = (a >= lsu_pkg::IO_BASE) && (a <= lsu_pkg::IO_LAST);
        exp_x     = 1'b0;
        exp_ready = 1'b0;
        exp_data  = '0;
        nacked    = 1'b0;
        if (kill_at < 0) begin
            if (note_accept() && !mis) begin
                nacked = 1'b1;
                void'(note_accept());                // Reissue after nack
            end
            if (mis) begin
                exp_x = 1'b1;
            end else if (is_st && !io) begin
                for (int i = 0; i < n; i++) begin
                    ref_mem[int'(a[10:0]) + i] = a_rs2[8*i +: 8];
                end
            end else if (!is_st) begin
                exp_ready = 1'b1;
                exp_data  = io ? '0 : load_value(a, f3);   // Window reads as zero
            end
        end else if (kill_at == 1) begin
            void'(note_accept());                    // Accepted then dropped
        end
        exp_lat = nacked ? 5 : 2;                    // Nack and reissue add three cycles
        run_instr(iw, a_rs1, a_rs2, kill_at);
        check_xcpt(exp_x, xcpt_cnt != 0);
        if (exp_ready && ready_cnt != 1) begin
            err_proto++;
            $display("Load at %h gave %0d ready pulses instead of one", a, ready_cnt);
        end else if (exp_ready) begin
            check_load(exp_data, got_data, dst, got_rd);
            if (ready_lat != exp_lat) begin
                err_proto++;
                $display("Load at %h answered after %0d cycles instead of %0d",
                         a, ready_lat, exp_lat);
            end
        end else if (ready_cnt != 0) begin
            err_proto++;
            $display("Unexpected ready pulse for access at %h", a);
        end
    endtask

    task automatic issue_illegal();
        logic [6:0]  op;
        logic [31:0] iw;
        op = 7'($urandom);
        if (op == lsu_pkg::OPC_LOAD || op == lsu_pkg::OPC_STORE) op[6] = ~op[6];
        case ($urandom_range(0, 2))
            0:       iw = {25'($urandom), op};                             // Non-memory opcode
            1:       iw = encode_load(3'b111, 5'($urandom), 12'($urandom));   // Reserved funct3
            default: iw = encode_store(3'($urandom_range(4, 7)), 12'($urandom));
        endcase
        run_instr(iw, {$urandom, $urandom}, {$urandom, $urandom}, -1);
        check_xcpt(1'b1, xcpt_cnt != 0);
        if (xcpt_cnt != 0 && xcpt_lat != 0) begin
            err_proto++;
            $display("Illegal instruction %h raised its exception after the issue cycle", iw);
        end
        if (lock_seen || ready_cnt != 0) begin
            err_proto++;
            $display("Illegal instruction %h locked the core or returned data", iw);
        end
    endtask

    // Main sequence
    initial begin
        int             kind;
        logic [2:0]     f3, off;
        logic           is_st;
        lsu_pkg::addr_t a, io_a, alias_a;
        void'($urandom(96));
        valid    = 1'b0;
        kill     = 1'b0;
        instr_w  = '0;
        rs1_data = '0;
        rs2_data = '0;
        {acc_cnt, n_instr, err_data, err_xcpt, err_proto} = '0;
        {ready_cnt, xcpt_cnt} = '0;
        since_issue = 0;
        ready_lat   = 0;
        xcpt_lat    = 0;
        lock_seen = 1'b0;
        wait (rstn);
        repeat (2) @(posedge clk);
        for (int w = 0; w < lsu_pkg::DMEM_WORDS; w++) begin
            do_access(1'b1, 3'd3, lsu_pkg::addr_t'(w * 8), -1);   // Fill RAM and model
        end
        while (n_instr < N_INSTR) begin
            kind = $urandom_range(0, 9);
            a    = lsu_pkg::addr_t'($urandom_range(0, 255) * 8);
            case (kind)
                0, 1, 2, 3, 4: begin   // Store, then every load kind
                    f3  = 3'($urandom_range(0, 3));
                    off = 3'($urandom_range(0, 7)) & ~3'((1 << f3) - 1);
                    do_access(1'b1, f3, a + off, -1);
                    for (int f = 0; f < 7; f++) begin
                        do_access(1'b0, 3'(f), a + off, -1);
                    end
                end
                5, 6: begin            // Misaligned access
                    is_st = 1'($urandom);
                    f3    = is_st ? 3'($urandom_range(1, 3)) : 3'($urandom_range(1, 6));
                    if (f3 == 3'd4) f3 = 3'd5;
                    off = 3'($urandom_range(1, (1 << f3[1:0]) - 1));
                    do_access(is_st, f3, a + off, -1);
                    do_access(1'b0, 3'd3, a, -1);
                end
                7: begin               // Kill, old data stays
                    do_access(1'($urandom), 3'd3, a, $urandom_range(0, 1));
                    do_access(1'b0, 3'd3, a, -1);
                end
                8: begin               // I/O window
                    io_a    = lsu_pkg::IO_BASE + lsu_pkg::addr_t'(8 * $urandom_range(0, 10));
                    alias_a = '0;
                    alias_a[10:3] = io_a[10:3];   // RAM word with the same index
                    do_access(1'b1, 3'($urandom_range(0, 3)), io_a, -1);
                    do_access(1'b0, 3'($urandom_range(0, 6)), io_a, -1);
                    do_access(1'b0, 3'd3, alias_a, -1);
                end
                default: issue_illegal();
            endcase
        end
        $display("Errors: data %0d, exception %0d, protocol %0d over %0d instructions",
                 err_data, err_xcpt, err_proto, n_instr);
        if (err_data + err_xcpt + err_proto == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
// Testbench clock and reset source
// 4 ns clock, active-low reset held for three rising edges
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;   // 4 ns period
    end

    initial begin
        rstn_o = 1'b0;
        repeat (3) @(posedge clk_o);
        #1 rstn_o = 1'b1;            // Release off the edge
    end

endmodule

/* verilog/lsu_top.sv */
// Load/store unit slice: decoder, memory unit, data cache and load formatter
`timescale 1ns/1ps

module lsu_top (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            valid_i,
    input  logic            kill_i,
    input  logic [31:0]     instr_i,
    input  lsu_pkg::bus64_t data_rs1_i,
    input  lsu_pkg::bus64_t data_rs2_i,
    output logic            lock_o,
    output logic            ready_o,
    output lsu_pkg::reg_t   rd_o,
    output lsu_pkg::bus64_t data_o,
    output logic            xcpt_o
);

    // Decode to execute
    lsu_pkg::instr_type_t instr_type;
    lsu_pkg::mem_op_t     mem_op;
    logic [2:0]           funct3;
    lsu_pkg::reg_t        rd;
    lsu_pkg::bus64_t      imm;

    // Execute to cache
    logic                 dmem_req_valid;
    lsu_pkg::dmem_cmd_t   dmem_req_cmd;
    lsu_pkg::addr_t       dmem_req_addr;
    logic [3:0]           dmem_op_type;
    lsu_pkg::bus64_t      dmem_req_data;
    logic                 dmem_req_kill;

    // Cache to execute
    logic                 dmem_req_ready;
    logic                 dmem_resp_valid;
    logic                 dmem_resp_nack;
    lsu_pkg::bus64_t      dmem_resp_data;
    logic                 dmem_xcpt_ma_ld;
    logic                 dmem_xcpt_ma_st;

    // Held access info for writeback
    logic [2:0]           width;
    logic [2:0]           offset;
    lsu_pkg::bus64_t      resp_raw;

    mem_decoder u_decoder (
        .instr_i      (instr_i),
        .instr_type_o (instr_type),
        .mem_op_o     (mem_op),
        .funct3_o     (funct3),
        .rd_o         (rd),
        .imm_o        (imm)
    );

    mem_unit u_mem_unit (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .valid_i           (valid_i),
        .kill_i            (kill_i),
        .data_rs1_i        (data_rs1_i),
        .data_rs2_i        (data_rs2_i),
        .instr_type_i      (instr_type),
        .mem_op_i          (mem_op),
        .funct3_i          (funct3),
        .rd_i              (rd),
        .imm_i             (imm),
        .dmem_req_ready_i  (dmem_req_ready),
        .dmem_resp_valid_i (dmem_resp_valid),
        .dmem_resp_nack_i  (dmem_resp_nack),
        .dmem_resp_data_i  (dmem_resp_data),
        .dmem_xcpt_ma_ld_i (dmem_xcpt_ma_ld),
        .dmem_xcpt_ma_st_i (dmem_xcpt_ma_st),
        .dmem_req_valid_o  (dmem_req_valid),
        .dmem_req_cmd_o    (dmem_req_cmd),
        .dmem_req_addr_o   (dmem_req_addr),
        .dmem_op_type_o    (dmem_op_type),
        .dmem_req_data_o   (dmem_req_data),
        .dmem_req_kill_o   (dmem_req_kill),
        .lock_o            (lock_o),
        .ready_o           (ready_o),
        .xcpt_o            (xcpt_o),
        .rd_o              (rd_o),
        .width_o           (width),
        .offset_o          (offset),
        .data_o            (resp_raw)
    );

    dcache_model u_dcache (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (dmem_req_valid),
        .req_cmd_i    (dmem_req_cmd),
        .req_addr_i   (dmem_req_addr),
        .op_type_i    (dmem_op_type),
        .req_data_i   (dmem_req_data),
        .req_kill_i   (dmem_req_kill),
        .req_ready_o  (dmem_req_ready),
        .resp_valid_o (dmem_resp_valid),
        .resp_nack_o  (dmem_resp_nack),
        .resp_data_o  (dmem_resp_data),
        .xcpt_ma_ld_o (dmem_xcpt_ma_ld),
        .xcpt_ma_st_o (dmem_xcpt_ma_st)
    );

    load_align u_align (
        .data_i   (resp_raw),
        .width_i  (width),
        .offset_i (offset),
        .data_o   (data_o)
    );

endmodule

/* verilog/load_align.sv */
// Load result formatter
// Picks the addressed bytes and extends them per funct3
`timescale 1ns/1ps

module load_align (
    input  lsu_pkg::bus64_t data_i,     // Raw 64-bit response
    input  logic [2:0]      width_i,    // funct3 of the load
    input  logic [2:0]      offset_i,   // Byte offset in word
    output lsu_pkg::bus64_t data_o
);

    lsu_pkg::bus64_t shifted;

    assign shifted = data_i >> {offset_i, 3'b000};   // Addressed byte to bit 0

    always_comb begin
        case (width_i)
            3'b000:  data_o = {{56{shifted[7]}}, shifted[7:0]};      // LB
            3'b001:  data_o = {{48{shifted[15]}}, shifted[15:0]};    // LH
            3'b010:  data_o = {{32{shifted[31]}}, shifted[31:0]};    // LW
            3'b100:  data_o = {56'd0, shifted[7:0]};                 // LBU
            3'b101:  data_o = {48'd0, shifted[15:0]};                // LHU
            3'b110:  data_o = {32'd0, shifted[31:0]};                // LWU
            default: data_o = shifted;                               // LD
        endcase
    end

endmodule

/* verilog/dcache_model.sv */
// Data cache stand-in, one access at a time, response two cycles after accept
// Periodic nack, misalign flags, I/O stores dropped without response
`timescale 1ns/1ps

module dcache_model (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_valid_i,
    input  lsu_pkg::dmem_cmd_t req_cmd_i,
    input  lsu_pkg::addr_t     req_addr_i,
    input  logic [3:0]         op_type_i,      // Low bits give access size
    input  lsu_pkg::bus64_t    req_data_i,     // Store data, LSB aligned
    input  logic               req_kill_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output logic               resp_nack_o,
    output lsu_pkg::bus64_t    resp_data_o,
    output logic               xcpt_ma_ld_o,
    output logic               xcpt_ma_st_o
);

    lsu_pkg::bus64_t ram [lsu_pkg::DMEM_WORDS];

    logic       s1_q, s2_q;     // Access in flag stage / response stage
    logic [2:0] acc_cnt_q;      // Accepted requests, mod 8
    logic       nack_q;         // Current access is the nacked one

    logic       accept;
    logic       st_req;
    logic       misal;
    logic       fire;
    logic [7:0] lane_mask;      // Bytes touched at offset 0
    logic [2:0] align_mask;     // Offset bits that must be zero

    // Payload of the accepted access
    logic [lsu_pkg::IDX_W-1:0] idx_q;
    lsu_pkg::bus64_t           wdata_q;
    logic [7:0]                be_q;
    logic                      st_q;
    logic                      io_q;

    assign req_ready_o = ~(s1_q | s2_q);
    assign accept      = req_valid_i & req_ready_o & ~req_kill_i;
    assign st_req      = (req_cmd_i == lsu_pkg::CMD_STORE);

    always_comb begin
        case (op_type_i[1:0])
            2'b00: begin
                lane_mask  = 8'h01;
                align_mask = 3'b000;
            end
            2'b01: begin
                lane_mask  = 8'h03;
                align_mask = 3'b001;
            end
            2'b10: begin
                lane_mask  = 8'h0F;
                align_mask = 3'b011;
            end
            default: begin
                lane_mask  = 8'hFF;
                align_mask = 3'b111;
            end
        endcase
    end

    assign misal = |(req_addr_i[2:0] & align_mask);

    // --------------------------------------------------
    // Pipeline control
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_q         <= 1'b0;
            s2_q         <= 1'b0;
            acc_cnt_q    <= '0;
            nack_q       <= 1'b0;
            xcpt_ma_ld_o <= 1'b0;
            xcpt_ma_st_o <= 1'b0;
        end else begin
            s1_q         <= accept;
            s2_q         <= s1_q & ~xcpt_ma_ld_o & ~xcpt_ma_st_o & ~req_kill_i;
            xcpt_ma_ld_o <= accept & misal & ~st_req;
            xcpt_ma_st_o <= accept & misal & st_req;
            if (accept) begin
                acc_cnt_q <= acc_cnt_q + 3'd1;
                nack_q    <= (acc_cnt_q == 3'd7);   // Every eighth request
            end
        end
    end

    assign fire         = s2_q & ~nack_q & ~req_kill_i;
    assign resp_nack_o  = s2_q & nack_q & ~req_kill_i;
    assign resp_valid_o = fire & ~(st_q & io_q);
    assign resp_data_o  = io_q ? '0 : ram[idx_q];   // I/O reads as zero

    // --------------------------------------------------
    // Payload and RAM
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (accept) begin
            idx_q   <= req_addr_i[3 +: lsu_pkg::IDX_W];
            be_q    <= lane_mask << req_addr_i[2:0];
            wdata_q <= req_data_i << {req_addr_i[2:0], 3'b000};
            st_q    <= st_req;
            io_q    <= lsu_pkg::in_io(req_addr_i);
        end
        if (fire & st_q & ~io_q) begin
            for (int b = 0; b < 8; b++) begin
                if (be_q[b]) begin
                    ram[idx_q][b*8 +: 8] <= wdata_q[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* verilog/mem_unit.sv */
// Memory unit: address generation, cache request FSM and core lock
// Holds the issued request so a nacked access can be reissued
`timescale 1ns/1ps

module mem_unit (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 valid_i,            // Issue pulse
    input  logic                 kill_i,             // Abort pending access
    input  lsu_pkg::bus64_t      data_rs1_i,         // Base address
    input  lsu_pkg::bus64_t      data_rs2_i,         // Store data
    input  lsu_pkg::instr_type_t instr_type_i,
    input  lsu_pkg::mem_op_t     mem_op_i,
    input  logic [2:0]           funct3_i,
    input  lsu_pkg::reg_t        rd_i,
    input  lsu_pkg::bus64_t      imm_i,
    // From cache
    input  logic                 dmem_req_ready_i,
    input  logic                 dmem_resp_valid_i,
    input  logic                 dmem_resp_nack_i,   // Request refused, reissue
    input  lsu_pkg::bus64_t      dmem_resp_data_i,
    input  logic                 dmem_xcpt_ma_ld_i,
    input  logic                 dmem_xcpt_ma_st_i,
    // To cache
    output logic                 dmem_req_valid_o,
    output lsu_pkg::dmem_cmd_t   dmem_req_cmd_o,
    output lsu_pkg::addr_t       dmem_req_addr_o,
    output logic [3:0]           dmem_op_type_o,
    output lsu_pkg::bus64_t      dmem_req_data_o,
    output logic                 dmem_req_kill_o,
    // To core
    output logic                 lock_o,             // No new issue allowed
    output logic                 ready_o,            // Load result valid
    output logic                 xcpt_o,
    output lsu_pkg::reg_t        rd_o,
    output logic [2:0]           width_o,            // funct3 of held access
    output logic [2:0]           offset_o,           // Byte offset in word
    output lsu_pkg::bus64_t      data_o              // Raw response word
);

    lsu_pkg::mu_state_t state_q, state_d;
    logic               replay_q, replay_d;   // Reissue from held request

    // Held request
    lsu_pkg::addr_t     addr_q;
    lsu_pkg::dmem_cmd_t cmd_q;
    logic [2:0]         funct3_q;
    lsu_pkg::bus64_t    data_q;
    lsu_pkg::reg_t      rd_q;
    logic               st_q;
    logic               io_st_q;              // Store into I/O window

    lsu_pkg::addr_t     addr_live;
    lsu_pkg::dmem_cmd_t cmd_live;
    logic               issue;
    logic               illegal;
    logic               pending;
    logic               mem_xcpt;

    // --------------------------------------------------
    // Request fields
    // --------------------------------------------------
    assign addr_live = data_rs1_i[lsu_pkg::ADDR_W-1:0] + imm_i[lsu_pkg::ADDR_W-1:0];
    assign issue     = (state_q == lsu_pkg::IDLE) & valid_i & ~replay_q;
    assign illegal   = (instr_type_i == lsu_pkg::ILLEGAL);
    assign pending   = replay_q | (issue & ~illegal);   // Something to send
    assign mem_xcpt  = dmem_xcpt_ma_ld_i | dmem_xcpt_ma_st_i;

    always_comb begin
        case (instr_type_i)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH, lsu_pkg::LHU,
            lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::LD: cmd_live = lsu_pkg::CMD_LOAD;
            lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW, lsu_pkg::SD: cmd_live = lsu_pkg::CMD_STORE;
            default: cmd_live = lsu_pkg::CMD_LOAD;
        endcase
    end

    // Live operands in the issue cycle, held copy on reissue
    assign dmem_req_addr_o = issue ? addr_live : addr_q;
    assign dmem_req_cmd_o  = issue ? cmd_live : cmd_q;
    assign dmem_op_type_o  = {1'b0, issue ? funct3_i : funct3_q};
    assign dmem_req_data_o = issue ? data_rs2_i : data_q;
    assign dmem_req_kill_o = kill_i | mem_xcpt | (issue & illegal);

    assign xcpt_o  = (issue & illegal) | ((state_q == lsu_pkg::MAKE_REQ) & mem_xcpt);
    assign ready_o = dmem_resp_valid_i & (state_q == lsu_pkg::WAIT_RESP) & ~st_q;
    assign rd_o     = rd_q;
    assign width_o  = funct3_q;
    assign offset_o = addr_q[2:0];
    assign data_o   = dmem_resp_data_i;

    always_ff @(posedge clk_i) begin
        if (issue) begin
            addr_q   <= addr_live;
            cmd_q    <= cmd_live;
            funct3_q <= funct3_i;
            data_q   <= data_rs2_i;
            rd_q     <= rd_i;
            st_q     <= (mem_op_i == lsu_pkg::MEM_STORE);
            io_st_q  <= (mem_op_i == lsu_pkg::MEM_STORE) & lsu_pkg::in_io(addr_live);
        end
    end

    // --------------------------------------------------
    // Control FSM, Mealy outputs
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q  <= lsu_pkg::RESET;
            replay_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            replay_q <= replay_d;
        end
    end

    always_comb begin
        state_d          = state_q;
        replay_d         = 1'b0;
        dmem_req_valid_o = 1'b0;
        lock_o           = 1'b0;
        case (state_q)
            lsu_pkg::RESET: begin
                state_d = lsu_pkg::IDLE;
            end
            lsu_pkg::IDLE: begin
                dmem_req_valid_o = pending & ~kill_i & dmem_req_ready_i;
                lock_o           = pending & ~kill_i;
                replay_d         = pending & ~kill_i & ~dmem_req_ready_i;   // Cache busy
                if (dmem_req_valid_o) begin
                    state_d = lsu_pkg::MAKE_REQ;
                end
            end
            lsu_pkg::MAKE_REQ: begin
                if (mem_xcpt | kill_i) begin
                    state_d = lsu_pkg::IDLE;        // Access dropped
                end else begin
                    lock_o  = 1'b1;
                    state_d = lsu_pkg::WAIT_RESP;
                end
            end
            lsu_pkg::WAIT_RESP: begin
                if (dmem_resp_valid_i) begin
                    state_d = lsu_pkg::IDLE;
                end else if (dmem_resp_nack_i) begin
                    lock_o   = ~kill_i;             // Stay locked for reissue
                    replay_d = ~kill_i;
                    state_d  = lsu_pkg::IDLE;
                end else if (kill_i | io_st_q) begin
                    state_d = lsu_pkg::IDLE;        // I/O store gets no response
                end else begin
                    lock_o = 1'b1;
                end
            end
            default: begin
                state_d = lsu_pkg::RESET;
            end
        endcase
    end

endmodule

/* verilog/mem_decoder.sv */
// Memory instruction decoder
// Opcode and funct3 to instruction type, access kind, rd and immediate
`timescale 1ns/1ps

module mem_decoder (
    input  logic [31:0]          instr_i,
    output lsu_pkg::instr_type_t instr_type_o,
    output lsu_pkg::mem_op_t     mem_op_o,
    output logic [2:0]           funct3_o,      // Width and sign of access
    output lsu_pkg::reg_t        rd_o,
    output lsu_pkg::bus64_t      imm_o          // Sign-extended offset
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct3_o = funct3;
    assign rd_o     = instr_i[11:7];   // Don't care for stores

    always_comb begin
        instr_type_o = lsu_pkg::ILLEGAL;
        mem_op_o     = lsu_pkg::MEM_NONE;
        imm_o        = '0;
        case (opcode)
            lsu_pkg::OPC_LOAD: begin
                imm_o    = {{52{instr_i[31]}}, instr_i[31:20]};   // I-type
                mem_op_o = lsu_pkg::MEM_LOAD;
                case (funct3)
                    3'b000:  instr_type_o = lsu_pkg::LB;
                    3'b001:  instr_type_o = lsu_pkg::LH;
                    3'b010:  instr_type_o = lsu_pkg::LW;
                    3'b011:  instr_type_o = lsu_pkg::LD;
                    3'b100:  instr_type_o = lsu_pkg::LBU;
                    3'b101:  instr_type_o = lsu_pkg::LHU;
                    3'b110:  instr_type_o = lsu_pkg::LWU;
                    default: mem_op_o     = lsu_pkg::MEM_NONE;   // Reserved
                endcase
            end
            lsu_pkg::OPC_STORE: begin
                // S-type, offset split around rd field
                imm_o    = {{52{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                mem_op_o = lsu_pkg::MEM_STORE;
                case (funct3)
                    3'b000:  instr_type_o = lsu_pkg::SB;
                    3'b001:  instr_type_o = lsu_pkg::SH;
                    3'b010:  instr_type_o = lsu_pkg::SW;
                    3'b011:  instr_type_o = lsu_pkg::SD;
                    default: mem_op_o     = lsu_pkg::MEM_NONE;
                endcase
            end
            default: begin
                // Not a memory opcode, keep defaults
                mem_op_o = lsu_pkg::MEM_NONE;
            end
        endcase
    end

endmodule

/* verilog/lsu_pkg.sv */
// Load/store unit shared definitions
// Widths, instruction and command encodings, FSM states, I/O window
package lsu_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int XLEN       = 64;
    localparam int ADDR_W     = 40;                  // Physical address
    localparam int REG_W      = 5;
    localparam int DMEM_WORDS = 256;                 // 64-bit words in cache RAM
    localparam int IDX_W      = $clog2(DMEM_WORDS);  // RAM index, address bits 10:3

    typedef logic [XLEN-1:0]   bus64_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [REG_W-1:0]  reg_t;

    // I/O window, inclusive bounds
    localparam addr_t IO_BASE = 40'h00_8002_0000;
    localparam addr_t IO_LAST = 40'h00_8002_0053;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OPC_LOAD  = 7'b0000011,
        OPC_STORE = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, LWU, LD,   // Loads
        SB, SH, SW, SD,                  // Stores
        ILLEGAL
    } instr_type_t;

    typedef enum logic [1:0] {
        MEM_LOAD,
        MEM_STORE,
        MEM_NONE
    } mem_op_t;

    // Cache command codes
    typedef enum logic [4:0] {
        CMD_LOAD  = 5'd0,
        CMD_STORE = 5'd1
    } dmem_cmd_t;

    // Memory unit control states
    typedef enum logic [1:0] {
        RESET     = 2'b00,
        IDLE      = 2'b01,
        MAKE_REQ  = 2'b10,
        WAIT_RESP = 2'b11
    } mu_state_t;

    // Address falls in the I/O window
    function automatic logic in_io(addr_t addr);
        return (addr >= IO_BASE) && (addr <= IO_LAST);
    endfunction

endpackage
